// File: verilog/policer_pkg.sv
/* Ingress policer package
   Widths, fixed-point types and configuration table codes */

`default_nettype none

package policer_pkg;

    //////////////////////////////////////////////////
    // Port sizing

    // Upper bound on ingress ports, sets the index width
    localparam int num_ports_max = 16;

    typedef logic [$clog2(num_ports_max)-1:0] port_idx_t;

    //////////////////////////////////////////////////
    // Descriptor fields

    typedef logic [2:0]  prio_t;
    // Up to a 1500 byte MTU
    typedef logic [10:0] byte_len_t;

    //////////////////////////////////////////////////
    // Token bucket arithmetic

    // Fraction bits shared by leak rate and bucket level
    localparam int frac_bits = 8;

    // CIR leak per clock, 8.8 fixed point
    typedef logic [15:0] leak_rate_t;

    // CBS threshold in whole bytes
    typedef logic [19:0] burst_size_t;

    // Bucket level, 20 whole bits and 8 fraction bits
    typedef logic [27:0] bucket_t;

    // Configuration write path
    typedef enum logic [1:0] {
        cfg_cir    = 2'd0,
        cfg_cbs    = 2'd1,
        cfg_enable = 2'd2
    } cfg_table_e;

    typedef logic [31:0] cfg_data_t;

endpackage

`default_nettype wire

// File: verilog/bucket_access_if.sv
/* Bucket lookup and charge path between the meter and the bucket bank */

`timescale 1ns/100ps
`default_nettype none

interface bucket_access_if import policer_pkg::*; ();

    port_idx_t lookup_port;
    // Current level of lookup_port, combinational
    bucket_t   level;
    // One cycle strobe, applied on the closing edge
    logic      charge;
    byte_len_t charge_len;

    modport meter (
        output lookup_port,
        output charge,
        output charge_len,
        input  level
    );

    modport bank (
        input  lookup_port,
        input  charge,
        input  charge_len,
        output level
    );

endinterface

`default_nettype wire

// File: verilog/policer_config_regs.sv
/* Policer configuration tables
   Per-port CIR, CBS and enable, updated by the write strobe */

`timescale 1ns/100ps
`default_nettype none

module policer_config_regs import policer_pkg::*; #(
    parameter int num_ports = 11
) (
    input  wire logic       core_clk_ifc,
    input  wire logic       timer_reset,

    input  wire logic       cfg_write,
    input  wire cfg_table_e cfg_table,
    input  wire port_idx_t  cfg_port,
    input  wire cfg_data_t  cfg_data,

    output leak_rate_t      leak_rates  [num_ports],
    output burst_size_t     burst_sizes [num_ports],
    output logic [num_ports-1:0] port_enables
);

    // Table entry views of the write data
    leak_rate_t  wr_leak;
    burst_size_t wr_burst;

    assign wr_leak  = cfg_data[$bits(leak_rate_t)-1:0];
    assign wr_burst = cfg_data[$bits(burst_size_t)-1:0];

    //////////////////////////////////////////////////
    // Table update

    // Ports at or above num_ports never match the loop index
    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            leak_rates   <= '{default: '0};
            burst_sizes  <= '{default: '0};
            port_enables <= '0;
        end else if (cfg_write) begin
            for (int i = 0; i < num_ports; i++) begin
                if (cfg_port == port_idx_t'(i)) begin
                    case (cfg_table)
                        cfg_cir:    leak_rates[i]   <= wr_leak;
                        cfg_cbs:    burst_sizes[i]  <= wr_burst;
                        cfg_enable: port_enables[i] <= cfg_data[0];
                        default:    ;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/policer_bucket_bank.sv
/* Token bucket bank
   One bucket per port, leaked every clock and charged by the meter */

`timescale 1ns/100ps
`default_nettype none

module policer_bucket_bank import policer_pkg::*; #(
    parameter int num_ports = 11
) (
    input  wire logic        core_clk_ifc,
    input  wire logic        timer_reset,

    input  wire leak_rate_t  leak_rates [num_ports],

    bucket_access_if.bank    access
);

    bucket_t buckets     [num_ports];
    bucket_t bucket_next [num_ports];
    bucket_t charge_amount;

    // Length in bytes moved up to the bucket's fixed point
    assign charge_amount = bucket_t'(access.charge_len) << frac_bits;

    //////////////////////////////////////////////////
    // Leak and charge

    always_comb begin
        for (int i = 0; i < num_ports; i++) begin
            // Leak saturates at an empty bucket
            if (buckets[i] > bucket_t'(leak_rates[i])) begin
                bucket_next[i] = buckets[i] - bucket_t'(leak_rates[i]);
            end else begin
                bucket_next[i] = '0;
            end

            // Meter only charges while whole level plus length fits the CBS
            if (access.charge && access.lookup_port == port_idx_t'(i)) begin
                bucket_next[i] = bucket_next[i] + charge_amount;
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            buckets <= '{default: '0};
        end else begin
            buckets <= bucket_next;
        end
    end

    //////////////////////////////////////////////////
    // Level lookup

    always_comb begin
        access.level = '0;
        for (int i = 0; i < num_ports; i++) begin
            if (access.lookup_port == port_idx_t'(i)) begin
                access.level = buckets[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/policer_meter.sv
/* Policer meter
   Compares bucket level plus length with the CBS, registers the marked descriptor */

`timescale 1ns/100ps
`default_nettype none

module policer_meter import policer_pkg::*; #(
    parameter int num_ports = 11
) (
    input  wire logic        core_clk_ifc,
    input  wire logic        timer_reset,

    input  wire burst_size_t burst_sizes [num_ports],
    input  wire logic [num_ports-1:0] port_enables,

    input  wire logic        in_valid,
    input  wire port_idx_t   in_ingress_port,
    input  wire port_idx_t   in_egress_port,
    input  wire prio_t       in_prio,
    input  wire byte_len_t   in_byte_length,

    bucket_access_if.meter   access,

    output logic             out_valid,
    output port_idx_t        out_ingress_port,
    output port_idx_t        out_egress_port,
    output prio_t            out_prio,
    output byte_len_t        out_byte_length,
    output logic             out_drop_mark
);

    // One extra bit so the sum cannot wrap
    typedef logic [$bits(burst_size_t):0] demand_t;

    burst_size_t port_cbs;
    logic        port_enabled;
    logic [$bits(bucket_t)-frac_bits-1:0] level_whole;
    demand_t     demand;
    logic        over_limit;

    // Settings of the incoming port, zero for ports beyond num_ports
    always_comb begin
        port_cbs     = '0;
        port_enabled = 1'b0;
        for (int i = 0; i < num_ports; i++) begin
            if (in_ingress_port == port_idx_t'(i)) begin
                port_cbs     = burst_sizes[i];
                port_enabled = port_enables[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // Decision

    assign access.lookup_port = in_ingress_port;
    assign level_whole        = access.level[$bits(bucket_t)-1:frac_bits];
    assign demand             = demand_t'(level_whole) + demand_t'(in_byte_length);
    assign over_limit         = port_enabled && (demand > demand_t'(port_cbs));

    // Charge accepted traffic on enabled ports only
    assign access.charge      = in_valid && port_enabled && !over_limit;
    assign access.charge_len  = in_byte_length;

    //////////////////////////////////////////////////
    // Output register

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            out_valid     <= 1'b0;
            out_drop_mark <= 1'b0;
        end else begin
            out_valid     <= in_valid;
            out_drop_mark <= in_valid && over_limit;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        out_ingress_port <= in_ingress_port;
        out_egress_port  <= in_egress_port;
        out_prio         <= in_prio;
        out_byte_length  <= in_byte_length;
    end

endmodule

`default_nettype wire

// File: verilog/ingress_policer.sv
/* Per-ingress-port token bucket policer
   Marks descriptors that exceed their port's committed burst */

`timescale 1ns/100ps
`default_nettype none

module ingress_policer import policer_pkg::*; #(
    parameter int num_ports = 11
) (
    input  wire logic       core_clk_ifc,
    input  wire logic       timer_reset,

    // Configuration strobe
    input  wire logic       cfg_write,
    input  wire cfg_table_e cfg_table,
    input  wire port_idx_t  cfg_port,
    input  wire cfg_data_t  cfg_data,

    // Descriptor in
    input  wire logic       in_valid,
    input  wire port_idx_t  in_ingress_port,
    input  wire port_idx_t  in_egress_port,
    input  wire prio_t      in_prio,
    input  wire byte_len_t  in_byte_length,

    // Descriptor out, one cycle later
    output logic            out_valid,
    output port_idx_t       out_ingress_port,
    output port_idx_t       out_egress_port,
    output prio_t           out_prio,
    output byte_len_t       out_byte_length,
    output logic            out_drop_mark
);

    leak_rate_t            leak_rates  [num_ports];
    burst_size_t           burst_sizes [num_ports];
    logic [num_ports-1:0]  port_enables;

    bucket_access_if bucket_bus ();

    policer_config_regs #(
        .num_ports    (num_ports)
    ) config_regs_i (
        .core_clk_ifc (core_clk_ifc),
        .timer_reset  (timer_reset),
        .cfg_write    (cfg_write),
        .cfg_table    (cfg_table),
        .cfg_port     (cfg_port),
        .cfg_data     (cfg_data),
        .leak_rates   (leak_rates),
        .burst_sizes  (burst_sizes),
        .port_enables (port_enables)
    );

    policer_bucket_bank #(
        .num_ports    (num_ports)
    ) bucket_bank_i (
        .core_clk_ifc (core_clk_ifc),
        .timer_reset  (timer_reset),
        .leak_rates   (leak_rates),
        .access       (bucket_bus.bank)
    );

    policer_meter #(
        .num_ports        (num_ports)
    ) meter_i (
        .core_clk_ifc     (core_clk_ifc),
        .timer_reset      (timer_reset),
        .burst_sizes      (burst_sizes),
        .port_enables     (port_enables),
        .in_valid         (in_valid),
        .in_ingress_port  (in_ingress_port),
        .in_egress_port   (in_egress_port),
        .in_prio          (in_prio),
        .in_byte_length   (in_byte_length),
        .access           (bucket_bus.meter),
        .out_valid        (out_valid),
        .out_ingress_port (out_ingress_port),
        .out_egress_port  (out_egress_port),
        .out_prio         (out_prio),
        .out_byte_length  (out_byte_length),
        .out_drop_mark    (out_drop_mark)
    );

endmodule

`default_nettype wire

// File: testbench/ingress_policer_asserts.sv
/* Ingress policer protocol assertions
   Bound into the top level, checks the one cycle pass-through */

`timescale 1ns/100ps
`default_nettype none

module ingress_policer_asserts import policer_pkg::*; (
    input wire logic      core_clk_ifc,
    input wire logic      timer_reset,
    input wire logic      in_valid,
    input wire port_idx_t in_ingress_port,
    input wire port_idx_t in_egress_port,
    input wire prio_t     in_prio,
    input wire byte_len_t in_byte_length,
    input wire logic      out_valid,
    input wire port_idx_t out_ingress_port,
    input wire port_idx_t out_egress_port,
    input wire prio_t     out_prio,
    input wire byte_len_t out_byte_length
);

    // Reset level on the previous edge
    logic reset_q = 1'b0;

    // Failed assertion count, read by the testbench at the end
    int fail_count = 0;

    always @(posedge core_clk_ifc) begin
        reset_q <= timer_reset;
    end

    //////////////////////////////////////////////////
    // Pass-through timing

    valid_follows_input: assert property (
        @(posedge core_clk_ifc) (!reset_q && !timer_reset) |-> out_valid == $past(in_valid)
    ) else begin
        fail_count++;
        $error("out_valid does not follow in_valid by one cycle");
    end

    fields_follow_input: assert property (
        @(posedge core_clk_ifc) (!reset_q && !timer_reset && out_valid) |->
            (out_ingress_port == $past(in_ingress_port)) &&
            (out_egress_port == $past(in_egress_port)) &&
            (out_prio == $past(in_prio)) &&
            (out_byte_length == $past(in_byte_length))
    ) else begin
        fail_count++;
        $error("descriptor fields changed on the way through");
    end

    // Output strobe cleared by reset
    valid_low_after_reset: assert property (
        @(posedge core_clk_ifc) reset_q |-> !out_valid
    ) else begin
        fail_count++;
        $error("out_valid high in the cycle after reset");
    end

endmodule

bind ingress_policer ingress_policer_asserts ingress_policer_asserts_i (.*);

`default_nettype wire

// File: testbench/ingress_policer_tb.sv
/* Ingress policer testbench
   Random descriptors checked against a token bucket reference model */

`timescale 1ns/100ps
`default_nettype none

module ingress_policer_tb import policer_pkg::*; ();

    localparam int num_ports  = 11;
    localparam int n_drop     = 200;
    localparam int n_accept   = 200;
    localparam int n_fill     = 300;
    localparam int n_disabled = 200;
    localparam int len_min    = 64;
    localparam int len_max    = 1500;
    localparam logic [15:0] lfsr_seed = 16'd87;

    // Slowest drain is 1000 bytes at 4 bytes per clock
    localparam int total_desc     = n_drop + n_accept + n_fill + 3 * num_ports + n_disabled + 3;
    localparam int idle_cycles    = num_ports * (1000 * 256 / 1024 + 16) + 5 * 4;
    localparam int cfg_cycles     = 5 * (3 * num_ports + 2);
    localparam int timeout_cycles = total_desc * 2 + idle_cycles + cfg_cycles + 500;

    logic       core_clk_ifc = 1'b0;
    logic       timer_reset;
    logic       cfg_write;
    cfg_table_e cfg_table;
    port_idx_t  cfg_port;
    cfg_data_t  cfg_data;
    logic       in_valid;
    port_idx_t  in_ingress_port;
    port_idx_t  in_egress_port;
    prio_t      in_prio;
    byte_len_t  in_byte_length;
    logic       out_valid;
    port_idx_t  out_ingress_port;
    port_idx_t  out_egress_port;
    prio_t      out_prio;
    byte_len_t  out_byte_length;
    logic       out_drop_mark;

    logic [15:0] lfsr_state = lfsr_seed;
    string       test_name  = "reset";
    int          mark_count = 0;

    // Reference model state, buckets in 1/256 byte units
    longint      model_bucket [num_ports];
    longint      model_cir    [num_ports];
    longint      model_cbs    [num_ports];
    logic        model_en     [num_ports];
    logic        exp_valid    = 1'b0;
    logic        exp_mark     = 1'b0;
    port_idx_t   exp_ingress;
    port_idx_t   exp_egress;
    prio_t       exp_prio;
    byte_len_t   exp_length;

    ingress_policer #(
        .num_ports (num_ports)
    ) ingress_policer_i (.*);

    always #5 core_clk_ifc = ~core_clk_ifc;

    //////////////////////////////////////////////////
    // Random sources

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic port_idx_t random_port();
        return port_idx_t'(rand_bits(4) % num_ports);
    endfunction

    function automatic byte_len_t random_len();
        return byte_len_t'(len_min + rand_bits(11) % (len_max - len_min + 1));
    endfunction

    //////////////////////////////////////////////////
    // Reference model and checks

    always @(posedge core_clk_ifc) begin : reference_model
        int     p;
        longint whole;
        logic   charge_now;
        p          = int'(in_ingress_port);
        charge_now = 1'b0;
        exp_mark   = 1'b0;
        if (timer_reset) begin
            model_bucket = '{default: 0};
            model_cir    = '{default: 0};
            model_cbs    = '{default: 0};
            model_en     = '{default: 1'b0};
            exp_valid    = 1'b0;
        end else begin
            // Decision sees the bucket and the tables of the input cycle
            if (in_valid && p < num_ports && model_en[p]) begin
                whole = model_bucket[p] / 256;
                if (whole + longint'(in_byte_length) > model_cbs[p]) begin
                    exp_mark = 1'b1;
                end else begin
                    charge_now = 1'b1;
                end
            end
            for (int i = 0; i < num_ports; i++) begin
                if (model_bucket[i] > model_cir[i]) begin
                    model_bucket[i] = model_bucket[i] - model_cir[i];
                end else begin
                    model_bucket[i] = 0;
                end
            end
            if (charge_now) begin
                model_bucket[p] = model_bucket[p] + longint'(in_byte_length) * 256;
            end
            if (cfg_write && int'(cfg_port) < num_ports) begin
                case (cfg_table)
                    cfg_cir:    model_cir[cfg_port] = longint'(cfg_data[15:0]);
                    cfg_cbs:    model_cbs[cfg_port] = longint'(cfg_data[19:0]);
                    cfg_enable: model_en[cfg_port]  = cfg_data[0];
                    default:    ;
                endcase
            end
            exp_valid = in_valid;
        end
        exp_ingress = in_ingress_port;
        exp_egress  = in_egress_port;
        exp_prio    = in_prio;
        exp_length  = in_byte_length;
    end

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("mismatch %s %s expected %0h actual %0h", test_name, field,
                     expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge core_clk_ifc) begin
        check_value("out_valid", 32'(exp_valid), 32'(out_valid));
        check_value("out_drop_mark", 32'(exp_mark), 32'(out_drop_mark));
        if (exp_valid) begin
            check_value("out_ingress_port", 32'(exp_ingress), 32'(out_ingress_port));
            check_value("out_egress_port", 32'(exp_egress), 32'(out_egress_port));
            check_value("out_prio", 32'(exp_prio), 32'(out_prio));
            check_value("out_byte_length", 32'(exp_length), 32'(out_byte_length));
            mark_count += int'(out_drop_mark);
        end
    end

    //////////////////////////////////////////////////
    // Drivers

    task automatic drive_cycle(input logic valid, input port_idx_t port, input byte_len_t len,
                               input logic wr, input cfg_table_e tbl,
                               input port_idx_t wport, input cfg_data_t data);
        @(posedge core_clk_ifc);
        in_valid        <= valid;
        in_ingress_port <= port;
        in_egress_port  <= port_idx_t'(rand_bits(4));
        in_prio         <= prio_t'(rand_bits(3));
        in_byte_length  <= len;
        cfg_write       <= wr;
        cfg_table       <= tbl;
        cfg_port        <= wport;
        cfg_data        <= data;
    endtask

    task automatic send(input port_idx_t port, input byte_len_t len);
        drive_cycle(1'b1, port, len, 1'b0, cfg_cir, '0, '0);
    endtask

    task automatic write_cfg(input cfg_table_e tbl, input port_idx_t port, input cfg_data_t data);
        drive_cycle(1'b0, '0, '0, 1'b1, tbl, port, data);
    endtask

    task automatic idle(input int count);
        repeat (count) drive_cycle(1'b0, '0, '0, 1'b0, cfg_cir, '0, '0);
    endtask

    task automatic apply_reset();
        timer_reset <= 1'b1;
        // A descriptor inside reset must not reach the output
        send(random_port(), random_len());
        idle(1);
        timer_reset <= 1'b0;
    endtask

    task automatic config_all(input cfg_data_t cir, input cfg_data_t cbs, input cfg_data_t en);
        for (int i = 0; i < num_ports; i++) begin
            write_cfg(cfg_cir, port_idx_t'(i), cir);
            write_cfg(cfg_cbs, port_idx_t'(i), cbs);
            write_cfg(cfg_enable, port_idx_t'(i), en);
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence

    initial begin : stimulus
        int          leak;
        int          drain;
        port_idx_t   port;
        logic [31:0] enable_mask;
        timer_reset     = 1'b1;
        cfg_write       = 1'b0;
        cfg_table       = cfg_cir;
        cfg_port        = '0;
        cfg_data        = '0;
        in_valid        = 1'b0;
        in_ingress_port = '0;
        in_egress_port  = '0;
        in_prio         = '0;
        in_byte_length  = '0;
        apply_reset();

        test_name = "drop_all";
        config_all(32'd0, 32'd0, 32'd1);
        mark_count = 0;
        repeat (n_drop) send(random_port(), random_len());
        idle(2);
        check_value("mark_count", 32'(n_drop), 32'(mark_count));

        test_name = "accept_all";
        apply_reset();
        config_all(32'hffff, 32'hfffff, 32'd1);
        mark_count = 0;
        repeat (n_accept) send(random_port(), random_len());
        idle(2);
        check_value("mark_count", 32'd0, 32'(mark_count));

        // No leak, accepted bytes pile up until the CBS is reached
        test_name = "cbs_fill";
        apply_reset();
        for (int i = 0; i < num_ports; i++) begin
            write_cfg(cfg_cbs, port_idx_t'(i), cfg_data_t'(rand_bits(14)));
            write_cfg(cfg_enable, port_idx_t'(i), 32'd1);
        end
        repeat (n_fill) send(random_port(), random_len());
        idle(2);

        // Full bucket, repeat just before it drains and again just after
        test_name = "cir_leak";
        apply_reset();
        for (int i = 0; i < num_ports; i++) begin
            leak  = int'(32'h400 + rand_bits(12));
            drain = (1000 * 256 + leak - 1) / leak;
            write_cfg(cfg_cir, port_idx_t'(i), cfg_data_t'(leak));
            write_cfg(cfg_cbs, port_idx_t'(i), 32'd1000);
            write_cfg(cfg_enable, port_idx_t'(i), 32'd1);
            send(port_idx_t'(i), 11'd1000);
            idle(drain - 4);
            send(port_idx_t'(i), 11'd1000);
            idle(8);
            send(port_idx_t'(i), 11'd1000);
        end
        idle(2);

        test_name = "disabled_ports";
        apply_reset();
        enable_mask = rand_bits(num_ports);
        for (int i = 0; i < num_ports; i++) begin
            write_cfg(cfg_enable, port_idx_t'(i), 32'(enable_mask[i]));
        end
        repeat (n_disabled) send(random_port(), random_len());
        // Enable flips alongside a descriptor, the next one sees the new value
        port = random_port();
        drive_cycle(1'b1, port, random_len(), 1'b1, cfg_enable, port, 32'(!enable_mask[port]));
        send(port, random_len());
        send(port, random_len());
        idle(2);

        if (ingress_policer_i.ingress_policer_asserts_i.fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("protocol assertions failed during the run");
            $display("SIMULATION FAILED");
            $fatal(1, "protocol assertions failed");
        end
    end

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge core_clk_ifc);
        $display("timeout: the test sequence did not finish in %0d cycles", timeout_cycles);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: all.f
verilog/policer_pkg.sv
verilog/bucket_access_if.sv
verilog/policer_config_regs.sv
verilog/policer_bucket_bank.sv
verilog/policer_meter.sv
verilog/ingress_policer.sv
testbench/ingress_policer_asserts.sv
testbench/ingress_policer_tb.sv

// File: Makefile
# Verilator build, run and lint for the ingress policer

VERILATOR ?= verilator
TOP       ?= ingress_policer_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_TEXT ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
